// ==== rtl/phys_pkg.sv ====
// shared widths, register counts and typedefs, imported by every rtl module of the rename block

package phys_pkg;

    // architectural side, riscv integer regs
    localparam int NUM_ARCH_REGS = 32;
    localparam int AREG_BITS     = $clog2(NUM_ARCH_REGS); // 5 bits for x0..x31

    // physical tag width, room for up to 128 physical regs
    localparam int PHREG_BITS = 7;

    // data path width
    localparam int XLEN = 64;

    // architectural register index
    typedef logic [AREG_BITS-1:0] areg_t;

    // physical register tag
    // tag 0 is hardwired zero in the regfile
    typedef logic [PHREG_BITS-1:0] phreg_t;

    // one data word as carried on writeback and read buses
    typedef logic [XLEN-1:0] bus64_t;

endpackage

// ==== rtl/phys_regfile.sv ====
// physical register file with NUM_WB write ports, two bypassed read ports and p0 tied to zero

`timescale 1ns/1ps

module phys_regfile #(
    parameter int NUM_PHYS_REGS = 64, // total tags incl. p0
    parameter int NUM_WB        = 2   // writeback ports
) (
    input  logic                                clk_i,

    // writeback ports, one bit or word per port
    input  logic             [NUM_WB-1:0]       wb_enable_i,
    input  phys_pkg::phreg_t [NUM_WB-1:0]       wb_tag_i,
    input  phys_pkg::bus64_t [NUM_WB-1:0]       wb_data_i,

    // read ports
    input  phys_pkg::phreg_t                    read_tag1_i,
    input  phys_pkg::phreg_t                    read_tag2_i,
    output phys_pkg::bus64_t                    read_data1_o,
    output phys_pkg::bus64_t                    read_data2_o
);

    import phys_pkg::*;

    // p0 has no storage, array starts at 1
    bus64_t regs_q [NUM_PHYS_REGS-1:1];

    // one read port worth of logic
    // zero for p0, then bypass from a matching wb port, then storage
    function automatic bus64_t read_port(input phreg_t tag);
        bus64_t fwd_data;
        logic   fwd_hit;
        fwd_data = '0;
        fwd_hit  = 1'b0;
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_enable_i[i] && (wb_tag_i[i] == tag)) begin
                fwd_data = wb_data_i[i]; // last matching port wins, dup tags are undefined anyway
                fwd_hit  = 1'b1;
            end
        end
        if (tag == '0) begin
            return '0;
        end
        if (fwd_hit) begin
            return fwd_data;
        end
        return regs_q[tag];
    endfunction

    // both read ports are purely combinational
    always_comb begin
        read_data1_o = read_port(read_tag1_i);
        read_data2_o = read_port(read_tag2_i);
    end

    // writes land at the rising edge
    // writes to p0 are dropped, nothing to store
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_enable_i[i] && (wb_tag_i[i] != '0)) begin
                regs_q[wb_tag_i[i]] <= wb_data_i[i];
            end
        end
    end

endmodule

// ==== rtl/rename_map.sv ====
// rename table from architectural reg to physical tag, combinational lookup and update on alloc

`timescale 1ns/1ps

module rename_map #(
    parameter int NUM_PHYS_REGS = 64 // sets how many tag bits the table really stores
) (
    input  logic              clk_i,
    input  logic              reset_i,

    // alloc strobe from top, already qualified with dest != 0 and free list not empty
    input  logic              alloc_i,

    input  phys_pkg::areg_t   src1_areg_i,
    input  phys_pkg::areg_t   src2_areg_i,
    input  phys_pkg::areg_t   dest_areg_i,
    input  phys_pkg::phreg_t  new_tag_i,   // head of free list

    output phys_pkg::phreg_t  src1_tag_o,
    output phys_pkg::phreg_t  src2_tag_o,
    output phys_pkg::phreg_t  old_tag_o    // previous mapping of dest, freed at commit
);

    import phys_pkg::*;

    // only enough bits to name NUM_PHYS_REGS tags
    localparam int TAG_W = $clog2(NUM_PHYS_REGS);

    logic [TAG_W-1:0] map_q [NUM_ARCH_REGS];

    // lookups see the table before this cycle's write
    // so src == dest gives the old tag, as the instruction reads before it writes
    assign src1_tag_o = phreg_t'(map_q[src1_areg_i]);
    assign src2_tag_o = phreg_t'(map_q[src2_areg_i]);
    assign old_tag_o  = phreg_t'(map_q[dest_areg_i]);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // identity map, xi -> pi
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= TAG_W'(i);
            end
        end else if (alloc_i) begin
            map_q[dest_areg_i] <= new_tag_i[TAG_W-1:0]; // x0 never allocates, stays at p0
        end
    end

endmodule

// ==== rtl/free_list.sv ====
// circular FIFO of free physical tags, pops on rename and takes tags back from commit

`timescale 1ns/1ps

module free_list #(
    parameter int NUM_PHYS_REGS = 64 // total tags incl. the 32 mapped at reset
) (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              pop_i,       // rename takes the head
    input  logic              push_i,      // commit returns a tag
    input  phys_pkg::phreg_t  push_tag_i,

    output phys_pkg::phreg_t  head_tag_o,  // next tag to hand out
    output logic              empty_o
);

    import phys_pkg::*;

    // tags not mapped after reset
    localparam int FL_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;
    localparam int PTR_W    = (FL_DEPTH > 1) ? $clog2(FL_DEPTH) : 1;
    localparam int CNT_W    = $clog2(FL_DEPTH + 1);

    phreg_t           entries_q [FL_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // wrap at FL_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FL_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_tag_o = entries_q[head_q];
    assign empty_o    = (count_q == '0);

    // pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;        // full, so tail wraps onto head
            count_q <= CNT_W'(FL_DEPTH);
        end else begin
            if (pop_i) begin
                head_q <= ptr_inc(head_q);
            end
            if (push_i) begin
                tail_q <= ptr_inc(tail_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    // storage
    // reset contents are the tags above the identity map, in ascending order
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                entries_q[i] <= phreg_t'(NUM_ARCH_REGS + i);
            end
        end else if (push_i) begin
            entries_q[tail_q] <= push_tag_i; // no overflow, tags in flight are bounded
        end
    end

endmodule

// ==== rtl/rename_regfile_top.sv ====
// top of the rename and physical register block, ties map, free list and regfile together

`timescale 1ns/1ps

module rename_regfile_top #(
    parameter int NUM_PHYS_REGS = 64, // 33..128
    parameter int NUM_WB        = 2
) (
    input  logic                          clk_i,
    input  logic                          reset_i,

    // rename request
    input  logic                          rename_valid_i,
    input  phys_pkg::areg_t               src1_areg_i,
    input  phys_pkg::areg_t               src2_areg_i,
    input  phys_pkg::areg_t               dest_areg_i,

    // commit frees the old tag of a retired instruction
    input  logic                          commit_valid_i,
    input  phys_pkg::phreg_t              commit_tag_i,

    // writeback
    input  logic             [NUM_WB-1:0] wb_enable_i,
    input  phys_pkg::phreg_t [NUM_WB-1:0] wb_tag_i,
    input  phys_pkg::bus64_t [NUM_WB-1:0] wb_data_i,

    // operand reads
    input  phys_pkg::phreg_t              read_tag1_i,
    input  phys_pkg::phreg_t              read_tag2_i,

    // rename results, same cycle as the request
    output phys_pkg::phreg_t              src1_tag_o,
    output phys_pkg::phreg_t              src2_tag_o,
    output phys_pkg::phreg_t              dest_tag_o,
    output phys_pkg::phreg_t              old_tag_o,
    output logic                          rename_stall_o,

    output phys_pkg::bus64_t              read_data1_o,
    output phys_pkg::bus64_t              read_data2_o
);

    import phys_pkg::*;

    phreg_t alloc_tag;   // free list head
    logic   free_empty;
    logic   alloc;       // one strobe for both map and free list
    logic   commit_push;

    // x0 never takes a tag, and nothing allocates while stalled
    assign alloc       = rename_valid_i && (dest_areg_i != '0) && !free_empty;
    assign commit_push = commit_valid_i && (commit_tag_i != '0); // p0 is never on the list

    assign dest_tag_o     = (dest_areg_i == '0) ? '0 : alloc_tag;
    assign rename_stall_o = free_empty;

    rename_map #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) i_rename_map (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .alloc_i     (alloc),
        .src1_areg_i (src1_areg_i),
        .src2_areg_i (src2_areg_i),
        .dest_areg_i (dest_areg_i),
        .new_tag_i   (alloc_tag),
        .src1_tag_o  (src1_tag_o),
        .src2_tag_o  (src2_tag_o),
        .old_tag_o   (old_tag_o)
    );

    free_list #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) i_free_list (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pop_i      (alloc),
        .push_i     (commit_push),
        .push_tag_i (commit_tag_i),
        .head_tag_o (alloc_tag),
        .empty_o    (free_empty)
    );

    // data side, independent of rename
    phys_regfile #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .NUM_WB        (NUM_WB)
    ) i_phys_regfile (
        .clk_i        (clk_i),
        .wb_enable_i  (wb_enable_i),
        .wb_tag_i     (wb_tag_i),
        .wb_data_i    (wb_data_i),
        .read_tag1_i  (read_tag1_i),
        .read_tag2_i  (read_tag2_i),
        .read_data1_o (read_data1_o),
        .read_data2_o (read_data2_o)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// clock and reset source for the rename block testbench, 8 ns period and reset held for a few cycles

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, like every other input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// ==== testbench/rename_regfile_properties.sv ====
// concurrent assertions on the rename block top, bound into it below

`timescale 1ns/1ps

module rename_regfile_properties (
    input logic              clk_i,
    input logic              reset_i,
    input logic              rename_valid_i,
    input phys_pkg::areg_t   dest_areg_i,
    input phys_pkg::phreg_t  dest_tag_i,
    input logic              rename_stall_i,
    input phys_pkg::phreg_t  read_tag1_i,
    input phys_pkg::bus64_t  read_data1_i
);

    int unsigned assert_fail_count = 0; // read by the testbench top

    // free list comes out of reset full
    stall_low_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> !rename_stall_i)
        else begin
            $error("rename_stall_o high right after reset");
            assert_fail_count++;
        end

    // an accepted rename never hands out p0
    dest_tag_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
        (rename_valid_i && (dest_areg_i != '0) && !rename_stall_i) |-> (dest_tag_i != '0))
        else begin
            $error("dest_tag_o is p0 for an accepted rename");
            assert_fail_count++;
        end

    p0_reads_zero: assert property (@(posedge clk_i) (read_tag1_i == '0) |-> (read_data1_i == '0))
        else begin
            $error("read_data1_o nonzero for p0");
            assert_fail_count++;
        end

endmodule

bind rename_regfile_top rename_regfile_properties i_rename_regfile_properties (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .rename_valid_i (rename_valid_i),
    .dest_areg_i    (dest_areg_i),
    .dest_tag_i     (dest_tag_o),
    .rename_stall_i (rename_stall_o),
    .read_tag1_i    (read_tag1_i),
    .read_data1_i   (read_data1_o)
);

// ==== testbench/rename_regfile_checker.sv ====
// reference model of the rename block, compares every DUT output with it at each rising edge

`timescale 1ns/1ps

module rename_regfile_checker #(
    parameter int NUM_PHYS_REGS = 64,
    parameter int NUM_WB        = 2
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          rename_valid_i,
    input  phys_pkg::areg_t               src1_areg_i,
    input  phys_pkg::areg_t               src2_areg_i,
    input  phys_pkg::areg_t               dest_areg_i,
    input  logic                          commit_valid_i,
    input  phys_pkg::phreg_t              commit_tag_i,
    input  logic             [NUM_WB-1:0] wb_enable_i,
    input  phys_pkg::phreg_t [NUM_WB-1:0] wb_tag_i,
    input  phys_pkg::bus64_t [NUM_WB-1:0] wb_data_i,
    input  phys_pkg::phreg_t              read_tag1_i,
    input  phys_pkg::phreg_t              read_tag2_i,
    // DUT outputs
    input  phys_pkg::phreg_t              src1_tag_i,
    input  phys_pkg::phreg_t              src2_tag_i,
    input  phys_pkg::phreg_t              dest_tag_i,
    input  phys_pkg::phreg_t              old_tag_i,
    input  logic                          rename_stall_i,
    input  phys_pkg::bus64_t              read_data1_i,
    input  phys_pkg::bus64_t              read_data2_i,
    output int                            error_count_o,
    output int                            check_count_o
);

    import phys_pkg::*;

    phreg_t model_map [NUM_ARCH_REGS];
    phreg_t model_free [$];               // head at index 0
    bus64_t model_regs [2**PHREG_BITS];
    bit     model_written [2**PHREG_BITS];
    int     errors = 0;
    int     checks = 0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    // expected read data: p0, then a same-cycle write, then the stored word
    function automatic bus64_t ref_read(input phreg_t tag);
        bus64_t data;
        data = model_regs[tag];
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_enable_i[i] && (wb_tag_i[i] == tag)) data = wb_data_i[i];
        end
        if (tag == '0) data = '0;
        return data;
    endfunction

    // false for a tag never written, its value is unknown
    function automatic bit read_known(input phreg_t tag);
        bit known;
        known = (tag == '0) || model_written[tag];
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_enable_i[i] && (wb_tag_i[i] == tag)) known = 1'b1;
        end
        return known;
    endfunction

    task automatic check_value(input string name, input bus64_t expected, input bus64_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic reset_model();
        model_free.delete();
        for (int i = 0; i < NUM_ARCH_REGS; i++) model_map[i] = phreg_t'(i); // identity
        for (int t = NUM_ARCH_REGS; t < NUM_PHYS_REGS; t++) model_free.push_back(phreg_t'(t));
        for (int t = 0; t < 2**PHREG_BITS; t++) model_written[t] = 1'b0;
    endtask

    task automatic compare_outputs();
        check_value("rename_stall_o", bus64_t'(model_free.size() == 0), bus64_t'(rename_stall_i));
        check_value("src1_tag_o", bus64_t'(model_map[src1_areg_i]), bus64_t'(src1_tag_i));
        check_value("src2_tag_o", bus64_t'(model_map[src2_areg_i]), bus64_t'(src2_tag_i));
        check_value("old_tag_o", bus64_t'(model_map[dest_areg_i]), bus64_t'(old_tag_i));
        if (dest_areg_i == '0) begin
            check_value("dest_tag_o", '0, bus64_t'(dest_tag_i));
        end else if (model_free.size() != 0) begin
            check_value("dest_tag_o", bus64_t'(model_free[0]), bus64_t'(dest_tag_i));
        end
        if (read_known(read_tag1_i)) check_value("read_data1_o", ref_read(read_tag1_i), read_data1_i);
        if (read_known(read_tag2_i)) check_value("read_data2_o", ref_read(read_tag2_i), read_data2_i);
    endtask

    task automatic update_model();
        bit alloc;
        alloc = rename_valid_i && (dest_areg_i != '0) && (model_free.size() != 0);
        if (alloc) model_map[dest_areg_i] = model_free.pop_front(); // pop sees the old occupancy
        if (commit_valid_i && (commit_tag_i != '0)) model_free.push_back(commit_tag_i);
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_enable_i[i] && (wb_tag_i[i] != '0)) begin
                model_regs[wb_tag_i[i]]    = wb_data_i[i];
                model_written[wb_tag_i[i]] = 1'b1;
            end
        end
    endtask

    // compare first, then step the model with the same sampled inputs
    always @(posedge clk_i) begin
        if (reset_i) begin
            reset_model();
        end else begin
            compare_outputs();
            update_model();
        end
    end

endmodule

// ==== testbench/rename_regfile_tb.sv ====
// testbench top for the rename block, seeded random stimulus on falling edges and the final verdict

`timescale 1ns/1ps

module rename_regfile_tb;

    import phys_pkg::*;

    localparam int NUM_PHYS_REGS = 64;
    localparam int NUM_WB        = 2;
    localparam int RESET_CYCLES  = 8;
    localparam int WB_CYCLES     = 40;
    localparam int RENAME_CYCLES = 20;
    localparam int STALL_LIMIT   = 40; // bound on the renames needed to drain the list
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 4 + WB_CYCLES + 20 + 10
                                   + 2 * RENAME_CYCLES + STALL_LIMIT + 12;
    localparam int TIMEOUT_NS    = TOTAL_CYCLES * 8 + 200;

    logic                 clk;
    logic                 reset;
    logic                 rename_valid;
    areg_t                src1_areg;
    areg_t                src2_areg;
    areg_t                dest_areg;
    logic                 commit_valid;
    phreg_t               commit_tag;
    logic   [NUM_WB-1:0]  wb_enable;
    phreg_t [NUM_WB-1:0]  wb_tag;
    bus64_t [NUM_WB-1:0]  wb_data;
    phreg_t               read_tag1;
    phreg_t               read_tag2;
    phreg_t               src1_tag;
    phreg_t               src2_tag;
    phreg_t               dest_tag;
    phreg_t               old_tag;
    logic                 rename_stall;
    bus64_t               read_data1;
    bus64_t               read_data2;
    int                   chk_errors;
    int                   chk_checks;
    int                   tb_fails;
    int                   errors_before;
    phreg_t               written_tags [$];   // only these are read back
    bit                   tag_written [2**PHREG_BITS];

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    rename_regfile_top #(.NUM_PHYS_REGS(NUM_PHYS_REGS), .NUM_WB(NUM_WB)) i_rename_regfile_top (
        .clk_i (clk), .reset_i (reset),
        .rename_valid_i (rename_valid), .src1_areg_i (src1_areg), .src2_areg_i (src2_areg),
        .dest_areg_i (dest_areg), .commit_valid_i (commit_valid), .commit_tag_i (commit_tag),
        .wb_enable_i (wb_enable), .wb_tag_i (wb_tag), .wb_data_i (wb_data),
        .read_tag1_i (read_tag1), .read_tag2_i (read_tag2),
        .src1_tag_o (src1_tag), .src2_tag_o (src2_tag), .dest_tag_o (dest_tag),
        .old_tag_o (old_tag), .rename_stall_o (rename_stall),
        .read_data1_o (read_data1), .read_data2_o (read_data2)
    );

    rename_regfile_checker #(.NUM_PHYS_REGS(NUM_PHYS_REGS), .NUM_WB(NUM_WB)) i_checker (
        .clk_i (clk), .reset_i (reset),
        .rename_valid_i (rename_valid), .src1_areg_i (src1_areg), .src2_areg_i (src2_areg),
        .dest_areg_i (dest_areg), .commit_valid_i (commit_valid), .commit_tag_i (commit_tag),
        .wb_enable_i (wb_enable), .wb_tag_i (wb_tag), .wb_data_i (wb_data),
        .read_tag1_i (read_tag1), .read_tag2_i (read_tag2),
        .src1_tag_i (src1_tag), .src2_tag_i (src2_tag), .dest_tag_i (dest_tag),
        .old_tag_i (old_tag), .rename_stall_i (rename_stall),
        .read_data1_i (read_data1), .read_data2_i (read_data2),
        .error_count_o (chk_errors), .check_count_o (chk_checks)
    );

    task automatic idle_inputs();
        rename_valid = 1'b0;
        src1_areg    = '0;
        src2_areg    = '0;
        dest_areg    = '0;
        commit_valid = 1'b0;
        commit_tag   = '0;
        wb_enable    = '0;
        wb_tag       = '0;
        wb_data      = '0;
        read_tag1    = '0;
        read_tag2    = '0;
    endtask

    function automatic areg_t random_areg();
        return areg_t'(1 + ($urandom % (NUM_ARCH_REGS - 1))); // x1..x31
    endfunction

    task automatic drive_rename(input areg_t dest);
        rename_valid = 1'b1;
        dest_areg    = dest;
        src1_areg    = areg_t'($urandom % NUM_ARCH_REGS);
        src2_areg    = areg_t'($urandom % NUM_ARCH_REGS);
        if ($urandom % 4 == 0) src1_areg = dest; // reads its own destination
    endtask

    // all ports busy, distinct tags, optionally port 0 aimed at p0
    task automatic random_writeback(input bit p0_on_port0);
        bit clash;
        for (int p = 0; p < NUM_WB; p++) begin
            do begin
                wb_tag[p] = phreg_t'(1 + ($urandom % (NUM_PHYS_REGS - 1)));
                clash     = 1'b0;
                for (int q = 0; q < p; q++) clash |= (wb_tag[q] == wb_tag[p]);
            end while (clash);
            if (p == 0 && p0_on_port0) wb_tag[p] = '0;
            wb_enable[p] = 1'b1;
            wb_data[p]   = {$urandom, $urandom};
            if (wb_tag[p] != '0 && !tag_written[wb_tag[p]]) begin
                tag_written[wb_tag[p]] = 1'b1;
                written_tags.push_back(wb_tag[p]);
            end
        end
    endtask

    function automatic phreg_t pick_written();
        return written_tags[$urandom % written_tags.size()];
    endfunction

    task automatic end_test(input string name);
        $display("test %-24s done, %0d errors", name, chk_errors + tb_fails - errors_before);
        errors_before = chk_errors + tb_fails;
    endtask

    initial begin
        int    n;
        areg_t stall_dest;
        void'($urandom(32'he3be_eb0d));
        idle_inputs();
        tb_fails      = 0;
        errors_before = 0;
        wait (reset === 1'b1);
        @(negedge reset);

        for (int c = 0; c < 4; c++) begin
            random_writeback(1'b1);
            @(negedge clk);
        end
        idle_inputs();
        end_test("p0 reads zero");

        for (int c = 0; c < WB_CYCLES; c++) begin
            random_writeback(1'b0);
            @(negedge clk);
        end
        idle_inputs();
        for (int c = 0; c < 20; c++) begin
            read_tag1 = pick_written();
            read_tag2 = pick_written();
            @(negedge clk);
        end
        end_test("writeback then read");

        for (int c = 0; c < 10; c++) begin
            random_writeback(1'b0);
            read_tag1 = wb_tag[0];
            read_tag2 = wb_tag[NUM_WB-1];
            @(negedge clk);
        end
        idle_inputs();
        end_test("same cycle forward");

        for (int c = 0; c < RENAME_CYCLES; c++) begin
            drive_rename(($urandom % 8 == 0) ? areg_t'(0) : random_areg());
            @(negedge clk);
        end
        idle_inputs();
        end_test("rename order");

        // pushes and pops balance, so committed tags surface once the reset tags are gone
        for (int c = 0; c < RENAME_CYCLES; c++) begin
            drive_rename(random_areg());
            commit_valid = 1'b1;
            commit_tag   = phreg_t'(c + 1);
            @(negedge clk);
        end
        idle_inputs();
        end_test("commit fifo order");

        n          = 0;
        stall_dest = random_areg();
        while (rename_stall !== 1'b1 && n < STALL_LIMIT) begin
            drive_rename(random_areg());
            @(negedge clk);
            n++;
        end
        if (rename_stall !== 1'b1) begin
            tb_fails++;
            $display("rename_stall_o never went high after %0d renames", n);
        end
        for (int c = 0; c < 4; c++) begin
            drive_rename(stall_dest); // dropped while stalled so the map entry must not move
            commit_valid = 1'b1;
            commit_tag   = '0;        // a p0 commit is ignored and keeps the stall
            @(negedge clk);
        end
        idle_inputs();
        commit_valid = 1'b1;
        commit_tag   = phreg_t'(RENAME_CYCLES + 1);
        @(negedge clk);
        idle_inputs();
        if (rename_stall !== 1'b0) begin
            tb_fails++;
            $display("rename_stall_o still high one cycle after a commit");
        end
        drive_rename(random_areg());
        @(negedge clk);
        idle_inputs();
        @(negedge clk);
        end_test("stall and release");

        $display("%0d checks, %0d errors, %0d other failures, %0d assertion failures",
                 chk_checks, chk_errors, tb_fails,
                 i_rename_regfile_top.i_rename_regfile_properties.assert_fail_count);
        if (chk_errors == 0 && tb_fails == 0 &&
            i_rename_regfile_top.i_rename_regfile_properties.assert_fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // sized from the phase lengths above
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/phys_pkg.sv
rtl/phys_regfile.sv
rtl/rename_map.sv
rtl/free_list.sv
rtl/rename_regfile_top.sv
testbench/tb_clock_gen.sv
testbench/rename_regfile_properties.sv
testbench/rename_regfile_checker.sv
testbench/rename_regfile_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the rename block testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module rename_regfile_tb -o rename_regfile_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/rename_regfile_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
